// File: Makefile
# Verilator flow for the mbus member layer, every variable can be set on the command line
VERILATOR ?= verilator
FILELIST  ?= mbus_member_layer.f
TB_TOP    ?= tb_mbus_member_layer
RTL_TOP   ?= mbus_member_layer
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert --timescale 1ns/100ps
PASS_MSG  ?= TB PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

# the run passes only if the pass line shows up in the output
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: mbus_member_layer.f
verilog/mbus_pkg.sv
verilog/layer_pkg.sv
verilog/mbus_sleep_ctrl.sv
verilog/mbus_wire_ctrl.sv
verilog/mbus_layer_power.sv
verilog/mbus_node_ctrl.sv
verilog/mbus_member_layer.sv
testbench/tb_mbus_member_layer.sv

// File: testbench/tb_mbus_member_layer.sv
`timescale 1ns/100ps
`default_nettype none

module tb_mbus_member_layer
	import mbus_pkg::*;
	import layer_pkg::*;
();

	localparam int clk_per = 8;
	localparam int bit_cycles = 8;	// clk_ext cycles per clkin level
	localparam int num_frames = 6;
	localparam int wd_cycles = num_frames * frame_bits * 16 + 2000;
	localparam logic [31:0] lfsr_seed = 32'hcec222b2;
	localparam logic [addr_width-1:0] node_addr = 8'h5a;
	localparam logic [addr_width-1:0] other_addr = 8'h3c;

	// one frame as seen on the ring
	typedef struct packed {
		logic                  arb;
		logic [addr_width-1:0] addr;
		logic [data_width-1:0] data;
		logic                  ack;
	} frame_rec_t;

	logic clk_ext, arst_n, clkin, din;
	logic clkout, dout;
	mbus_msg_t tx_msg;
	logic tx_req, tx_ack, tx_succ, tx_fail, tx_resp_ack;
	mbus_msg_t rx_msg;
	logic rx_req, rx_ack;
	layer_ctrl_t layer_ctrl;
	logic req_int, wakeup_proc;

	logic [31:0] lfsr;
	logic rx_expected;		// a delivery is due for the current frame
	mbus_msg_t exp_rx;

	mbus_member_layer #(.short_addr(node_addr)) dut_i (.*);

	always #(clk_per / 2) clk_ext = ~clk_ext;

	task automatic report_error(input string msg);
		$display("error at %0t: %s", $time, msg);
		$display("TB FAILED");
		$fatal(1, "stopping on first error");
	endtask

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic draw_bits(input int n, output logic [31:0] val);
		val = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			val = {val[30:0], lfsr[0]};
		end
	endtask

	function automatic frame_rec_t make_frame(input logic arb, input logic [addr_width-1:0] addr,
			input logic [data_width-1:0] data, input logic ack);
		frame_rec_t f;
		f.arb = arb;
		f.addr = addr;
		f.data = data;
		f.ack = ack;
		return f;
	endfunction

	task automatic idle_cycles(input int n);
		repeat (n) @(posedge clk_ext);
	endtask

	// mediator side of one frame with dout captured just before each rising clkin
	task automatic send_frame(input frame_rec_t sent, input frame_rec_t expect_rec);
		logic [frame_bits-1:0] bits;
		logic [frame_bits-1:0] seen;
		bits = sent;
		seen = '0;
		for (int i = frame_bits - 1; i >= 0; i--) begin
			@(posedge clk_ext);
			clkin <= 1'b0;
			din <= bits[i];		// data moves on the falling edge
			idle_cycles(bit_cycles - 1);
			@(negedge clk_ext);
			seen[i] = dout;
			@(posedge clk_ext);
			clkin <= 1'b1;
			idle_cycles(bit_cycles - 1);
		end
		@(posedge clk_ext);
		din <= 1'b1;	// back to idle
		assert (frame_rec_t'(seen) == expect_rec) else
			report_error($sformatf("dout frame %h, expected %h", seen, expect_rec));
	endtask

	task automatic take_rx();
		wait (rx_req);
		@(posedge clk_ext);
		rx_ack <= 1'b1;
		wait (!rx_req);
		@(posedge clk_ext);
		rx_ack <= 1'b0;
	endtask

	task automatic run_rx(input logic [addr_width-1:0] addr, input logic deliver,
			input logic node_acks);
		logic [31:0] d;
		draw_bits(data_width, d);
		exp_rx.addr = addr;
		exp_rx.data = d;
		exp_rx.broadcast = (addr == broadcast_addr);
		rx_expected = deliver;
		send_frame(make_frame(1'b0, addr, d, 1'b1), make_frame(1'b0, addr, d, !node_acks));
		if (deliver)
			take_rx();
		rx_expected = 1'b0;
		idle_cycles(16);
	endtask

	// node owns the frame while upstream leaves din high except for the ack
	task automatic run_tx(input logic ack_in);
		mbus_msg_t msg;
		logic [31:0] r;
		draw_bits(addr_width, r);
		msg.addr = r[addr_width-1:0];
		draw_bits(data_width, r);
		msg.data = r;
		msg.broadcast = 1'b0;
		@(posedge clk_ext);
		tx_msg <= msg;
		tx_req <= 1'b1;
		wait (tx_ack);
		@(posedge clk_ext);
		tx_req <= 1'b0;
		wait (!tx_ack);
		send_frame(make_frame(1'b1, '1, '1, ack_in),
			make_frame(1'b0, msg.addr, msg.data, ack_in));
		assert (tx_succ == !ack_in && tx_fail == ack_in) else
			report_error($sformatf("tx succ %b fail %b for ack bit %b",
				tx_succ, tx_fail, ack_in));
		@(posedge clk_ext);
		tx_resp_ack <= 1'b1;
		wait (!tx_succ && !tx_fail);
		@(posedge clk_ext);
		tx_resp_ack <= 1'b0;
		idle_cycles(16);
	endtask

	task automatic wake_by_interrupt();
		@(posedge clk_ext);
		req_int <= 1'b1;
		idle_cycles(2);
		@(negedge clk_ext);
		assert (!dout) else
			report_error("interrupt request did not pull dout low on the idle bus");
		wait (!dut_i.iso);
		@(posedge clk_ext);
		req_int <= 1'b0;
		wait (!dut_i.int_pending);
		@(posedge clk_ext);
		assert (dout) else
			report_error("dout still held low after the node woke");
	endtask

	after_reset: assert property (@(posedge clk_ext) $rose(arst_n) |->
		layer_ctrl == '0 && !rx_req && !tx_ack && !tx_succ && !tx_fail && dut_i.iso)
		else report_error("outputs not in reset state");

	bypass_clk: assert property (@(posedge clk_ext) disable iff (!arst_n)
		dut_i.iso |-> clkout == clkin) else report_error("clkout does not follow clkin");
	bypass_data: assert property (@(posedge clk_ext) disable iff (!arst_n)
		dut_i.iso && !dut_i.int_pending |-> dout == din)
		else report_error("dout does not follow din");
	int_pull: assert property (@(posedge clk_ext) disable iff (!arst_n)
		dut_i.iso && dut_i.int_pending && clkin |-> !dout)
		else report_error("pending interrupt not driven on dout");

	// layer control steps one per cycle
	up_clk: assert property (@(posedge clk_ext) disable iff (!arst_n)
		$rose(layer_ctrl.release_clk) |-> $past(layer_ctrl.power_on))
		else report_error("release_clk rose before power_on");
	up_iso: assert property (@(posedge clk_ext) disable iff (!arst_n)
		$rose(layer_ctrl.release_iso) |-> $past(layer_ctrl.release_clk))
		else report_error("release_iso rose before release_clk");
	up_rst: assert property (@(posedge clk_ext) disable iff (!arst_n)
		$rose(layer_ctrl.release_rst) |-> $past(layer_ctrl.release_iso))
		else report_error("release_rst rose before release_iso");
	down_pwr: assert property (@(posedge clk_ext) disable iff (!arst_n)
		$fell(layer_ctrl.power_on) |-> $past(!layer_ctrl.release_clk))
		else report_error("power_on fell before release_clk");
	down_clk: assert property (@(posedge clk_ext) disable iff (!arst_n)
		$fell(layer_ctrl.release_clk) |-> $past(!layer_ctrl.release_iso))
		else report_error("release_clk fell before release_iso");
	down_iso: assert property (@(posedge clk_ext) disable iff (!arst_n)
		$fell(layer_ctrl.release_iso) |-> $past(!layer_ctrl.release_rst))
		else report_error("release_iso fell before release_rst");

	rx_deliver: assert property (@(posedge clk_ext) disable iff (!arst_n)
		$rose(rx_req) |-> rx_expected && rx_msg == exp_rx && $past(layer_ctrl.release_rst))
		else report_error("unexpected rx_req or wrong rx_msg");
	rx_hold: assert property (@(posedge clk_ext) disable iff (!arst_n)
		rx_req && !rx_ack |=> rx_req) else report_error("rx_req dropped before rx_ack");
	tx_ack_drop: assert property (@(posedge clk_ext) disable iff (!arst_n)
		tx_ack && !tx_req |=> !tx_ack) else report_error("tx_ack held after tx_req fell");
	tx_resp_hold: assert property (@(posedge clk_ext) disable iff (!arst_n)
		(tx_succ || tx_fail) && !tx_resp_ack |=> (tx_succ || tx_fail))
		else report_error("tx result dropped before tx_resp_ack");
	tx_resp_clear: assert property (@(posedge clk_ext) disable iff (!arst_n)
		tx_resp_ack |=> !tx_succ && !tx_fail)
		else report_error("tx result kept after tx_resp_ack");
	tx_one_result: assert property (@(posedge clk_ext) disable iff (!arst_n)
		!(tx_succ && tx_fail)) else report_error("tx_succ and tx_fail both high");

	initial begin
		clk_ext = 1'b0;
		arst_n = 1'b0;
		clkin = 1'b1;
		din = 1'b1;
		tx_msg = '0;
		tx_req = 1'b0;
		tx_resp_ack = 1'b0;
		rx_ack = 1'b0;
		req_int = 1'b0;
		wakeup_proc = 1'b0;
		lfsr = lfsr_seed;
		rx_expected = 1'b0;
		exp_rx = '0;
		idle_cycles(8);
		arst_n <= 1'b1;
		idle_cycles(16);
		run_rx(node_addr, 1'b1, 1'b1);		// wakes the node
		assert (layer_ctrl == '1) else
			report_error("layer not fully released after delivery");
		run_rx(other_addr, 1'b0, 1'b0);
		run_rx(broadcast_addr, 1'b1, 1'b1);
		run_tx(1'b0);
		run_tx(1'b1);
		run_rx(sleep_addr, 1'b0, 1'b1);
		wait (layer_ctrl == '0 && dut_i.iso);
		idle_cycles(16);
		wake_by_interrupt();
		idle_cycles(16);
		$display("TB PASSED");
		$finish;
	end

	initial begin
		repeat (wd_cycles) @(posedge clk_ext);
		$display("timeout: test did not finish within %0d clock cycles", wd_cycles);
		$display("TB FAILED");
		$fatal(1, "watchdog expired");
	end

endmodule

`default_nettype wire

// File: verilog/layer_pkg.sv
`default_nettype none

package layer_pkg;

	// cycles spent in waking before the node is released
	localparam int wake_cycles = 2;
	localparam int wake_cnt_width = 2;

	// always-on sleep controller states
	typedef enum logic [1:0] {
		st_asleep,
		st_waking,
		st_active
	} sleep_state_e;

	// layer power sequence, one step per cycle in either direction
	typedef enum logic [2:0] {
		step_off,
		step_power_on,
		step_clk_on,
		step_iso_off,
		step_rst_off
	} pwr_step_e;

	// the four layer control outputs
	typedef struct packed {
		logic power_on;
		logic release_clk;
		logic release_iso;
		logic release_rst;
	} layer_ctrl_t;

endpackage

`default_nettype wire

// File: verilog/mbus_layer_power.sv
`timescale 1ns/100ps
`default_nettype none

module mbus_layer_power
	import layer_pkg::*;
(
	input  wire         clk_ext,
	input  wire         arst_n,
	input  wire         pwr_up_req,
	input  wire         pwr_down_req,
	output layer_ctrl_t layer_ctrl,
	output logic        layer_ready
);

	pwr_step_e step;
	pwr_step_e step_next;
	logic going_up;
	logic going_up_q;

	// latest request decides the direction
	always_comb begin
		going_up = going_up_q;
		if (pwr_up_req)
			going_up = 1'b1;
		if (pwr_down_req)
			going_up = 1'b0;
	end

	always_comb begin
		step_next = step;
		case (step)
			step_off:      step_next = going_up ? step_power_on : step_off;
			step_power_on: step_next = going_up ? step_clk_on : step_off;
			step_clk_on:   step_next = going_up ? step_iso_off : step_power_on;
			step_iso_off:  step_next = going_up ? step_rst_off : step_clk_on;
			step_rst_off:  step_next = going_up ? step_rst_off : step_iso_off;
			default:       step_next = step_off;
		endcase
	end

	always_ff @(posedge clk_ext or negedge arst_n) begin
		if (!arst_n) begin
			step <= step_off;
			going_up_q <= 1'b0;
		end else begin
			step <= step_next;
			going_up_q <= going_up;
		end
	end

	// thermometer decode of the current step
	assign layer_ctrl.power_on = (step != step_off);
	assign layer_ctrl.release_clk = (step inside {step_clk_on, step_iso_off, step_rst_off});
	assign layer_ctrl.release_iso = (step inside {step_iso_off, step_rst_off});
	assign layer_ctrl.release_rst = (step == step_rst_off);
	assign layer_ready = (step == step_rst_off);

	rst_needs_power: assert property (@(posedge clk_ext) disable iff (!arst_n)
		layer_ctrl.release_rst |-> layer_ctrl.power_on);

endmodule

`default_nettype wire

// File: verilog/mbus_member_layer.sv
`timescale 1ns/100ps
`default_nettype none

module mbus_member_layer
	import mbus_pkg::*;
	import layer_pkg::*;
#(
	parameter logic [addr_width-1:0] short_addr = 8'h5a
) (
	input  wire         clk_ext,
	input  wire         arst_n,
	input  wire         clkin,
	input  wire         din,
	output logic        clkout,
	output logic        dout,
	input  mbus_msg_t   tx_msg,
	input  wire         tx_req,
	output logic        tx_ack,
	output logic        tx_succ,
	output logic        tx_fail,
	input  wire         tx_resp_ack,
	output mbus_msg_t   rx_msg,
	output logic        rx_req,
	input  wire         rx_ack,
	output layer_ctrl_t layer_ctrl,
	input  wire         req_int,
	input  wire         wakeup_proc
);

	logic node_en, iso, rst_release;
	logic sleep_req;
	logic pwr_up_req, pwr_down_req, layer_ready;
	logic node_dout, node_clkout;
	logic clr_int, int_pending;

	// always on
	mbus_sleep_ctrl s0 (
		.clk_ext(clk_ext), .arst_n(arst_n), .din(din),
		.wakeup_proc(wakeup_proc), .int_pending(int_pending), .sleep_req(sleep_req),
		.node_en(node_en), .iso(iso), .rst_release(rst_release)
	);

	mbus_node_ctrl #(.short_addr(short_addr)) m0 (
		.clk_ext(clk_ext), .arst_n(arst_n), .node_en(node_en), .rst_release(rst_release),
		.clkin(clkin), .din(din), .node_dout(node_dout), .node_clkout(node_clkout),
		.tx_msg(tx_msg), .tx_req(tx_req), .tx_ack(tx_ack),
		.tx_succ(tx_succ), .tx_fail(tx_fail), .tx_resp_ack(tx_resp_ack),
		.rx_msg(rx_msg), .rx_req(rx_req), .rx_ack(rx_ack),
		.wakeup_proc(wakeup_proc), .layer_ready(layer_ready),
		.pwr_up_req(pwr_up_req), .pwr_down_req(pwr_down_req),
		.sleep_req(sleep_req), .clr_int(clr_int)
	);

	mbus_layer_power lp0 (
		.clk_ext(clk_ext), .arst_n(arst_n),
		.pwr_up_req(pwr_up_req), .pwr_down_req(pwr_down_req),
		.layer_ctrl(layer_ctrl), .layer_ready(layer_ready)
	);

	// always on, passes the ring through while isolated
	mbus_wire_ctrl wc0 (
		.clk_ext(clk_ext), .arst_n(arst_n), .din(din), .clkin(clkin), .iso(iso),
		.node_dout(node_dout), .node_clkout(node_clkout),
		.req_int(req_int), .clr_int(clr_int),
		.dout(dout), .clkout(clkout), .int_pending(int_pending)
	);

endmodule

`default_nettype wire

// File: verilog/mbus_node_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module mbus_node_ctrl
	import mbus_pkg::*;
#(
	parameter logic [addr_width-1:0] short_addr = 8'h5a
) (
	input  wire       clk_ext,
	input  wire       arst_n,
	input  wire       node_en,
	input  wire       rst_release,
	input  wire       clkin,
	input  wire       din,
	output logic      node_dout,
	output logic      node_clkout,
	input  mbus_msg_t tx_msg,
	input  wire       tx_req,
	output logic      tx_ack,
	output logic      tx_succ,
	output logic      tx_fail,
	input  wire       tx_resp_ack,
	output mbus_msg_t rx_msg,
	output logic      rx_req,
	input  wire       rx_ack,
	input  wire       wakeup_proc,
	input  wire       layer_ready,
	output logic      pwr_up_req,
	output logic      pwr_down_req,
	output logic      sleep_req,
	output logic      clr_int
);

	frame_phase_e phase;
	logic [cnt_width-1:0] bit_cnt;
	logic [1:0] clkin_sync, din_sync;
	logic clkin_d, clkin_rise, clkin_fall, din_s;
	logic node_rst_n;
	logic drive_en, drive_bit;
	logic tx_pend, tx_own;
	logic rx_acc, rx_sleep, rx_valid;
	logic sleep_wait, rst_d;
	logic tx_load, bit_fall, bit_rise, rx_store;
	logic [addr_width-1:0] addr_now;
	logic [msg_bits-1:0] tx_shift, rx_shift;

	// node logic sits in reset until the sleep ctrl releases it
	assign node_rst_n = arst_n & rst_release;

	// bus inputs are sampled whether awake or not
	always_ff @(posedge clk_ext or negedge arst_n) begin
		if (!arst_n) begin
			clkin_sync <= 2'b11;
			din_sync <= 2'b11;
			clkin_d <= 1'b1;
		end else begin
			clkin_sync <= {clkin_sync[0], clkin};
			din_sync <= {din_sync[0], din};
			clkin_d <= clkin_sync[1];
		end
	end

	assign din_s = din_sync[1];
	assign clkin_rise = clkin_sync[1] & ~clkin_d;
	assign clkin_fall = ~clkin_sync[1] & clkin_d;
	assign node_clkout = clkin_d;	// data leads the forwarded clock by a cycle
	assign node_dout = drive_en ? drive_bit : din_s;
	assign addr_now = {rx_shift[addr_width-2:0], din_s};

	// strobes shared by the control and payload registers
	assign tx_load = node_en & tx_req & ~tx_ack & ~tx_pend & ~tx_succ & ~tx_fail;
	assign bit_fall = node_en & clkin_fall & tx_own & (phase inside {ph_addr, ph_data});
	assign bit_rise = node_en & clkin_rise & (phase inside {ph_addr, ph_data});
	assign rx_store = node_en & (phase == ph_done) & rx_acc & ~rx_sleep;

	always_ff @(posedge clk_ext or negedge node_rst_n) begin
		if (!node_rst_n) begin
			phase <= ph_idle;
			bit_cnt <= '0;
			drive_en <= 1'b0;
			drive_bit <= 1'b1;
			tx_pend <= 1'b0;
			tx_own <= 1'b0;
			tx_ack <= 1'b0;
			tx_succ <= 1'b0;
			tx_fail <= 1'b0;
			rx_acc <= 1'b0;
			rx_sleep <= 1'b0;
			rx_valid <= 1'b0;
			rx_req <= 1'b0;
			pwr_up_req <= 1'b0;
			pwr_down_req <= 1'b0;
			sleep_req <= 1'b0;
			sleep_wait <= 1'b0;
			clr_int <= 1'b0;
			rst_d <= 1'b0;
		end else if (node_en) begin
			pwr_up_req <= 1'b0;		// single-cycle pulses
			pwr_down_req <= 1'b0;
			sleep_req <= 1'b0;
			clr_int <= 1'b0;
			rst_d <= 1'b1;
			if (!rst_d) begin
				clr_int <= 1'b1;		// first active cycle
				pwr_up_req <= wakeup_proc;
			end
			if (tx_load) begin
				tx_pend <= 1'b1;
				tx_ack <= 1'b1;
			end else if (tx_ack && !tx_req) begin
				tx_ack <= 1'b0;
			end
			if (tx_resp_ack) begin
				tx_succ <= 1'b0;
				tx_fail <= 1'b0;
			end
			if (rx_valid && layer_ready && !rx_req && !rx_ack) begin
				rx_req <= 1'b1;
			end else if (rx_req && rx_ack) begin
				rx_req <= 1'b0;
				rx_valid <= 1'b0;
			end
			if (sleep_wait && !layer_ready) begin	// layer on its way down
				sleep_req <= 1'b1;
				sleep_wait <= 1'b0;
			end
			case (phase)
				ph_idle, ph_arb: begin
					if (clkin_fall) begin
						phase <= ph_arb;
						drive_en <= tx_pend;		// request the bus
						drive_bit <= 1'b0;
					end else if (clkin_rise) begin
						// won only if nobody upstream pulled din low
						tx_own <= tx_pend & drive_en & din_s;
						drive_en <= tx_pend & drive_en & din_s;
						bit_cnt <= cnt_width'(1);
						phase <= ph_addr;
					end
				end
				ph_addr, ph_data: begin
					if (bit_fall) begin
						drive_bit <= tx_shift[msg_bits-1];
					end else if (bit_rise) begin
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == cnt_width'(addr_width)) begin
							phase <= ph_data;
							rx_sleep <= (addr_now == sleep_addr);
							rx_acc <= !tx_own && ((addr_now == sleep_addr) ||
								((addr_now == short_addr || addr_now == broadcast_addr) &&
								!rx_valid));		// busy receiver drops the frame
						end else if (bit_cnt == cnt_width'(frame_bits - 2)) begin
							phase <= ph_ack;
						end
					end
				end
				ph_ack: begin
					if (clkin_fall) begin
						drive_en <= rx_acc;		// ack is active low
						drive_bit <= 1'b0;
					end else if (clkin_rise) begin
						drive_en <= 1'b0;
						phase <= ph_done;
						if (tx_own) begin
							tx_succ <= !din_s;
							tx_fail <= din_s;
							tx_pend <= 1'b0;
						end
					end
				end
				ph_done: begin
					phase <= ph_idle;
					tx_own <= 1'b0;
					rx_acc <= 1'b0;
					if (rx_acc && rx_sleep) begin
						pwr_down_req <= 1'b1;
						sleep_wait <= 1'b1;
					end else if (rx_acc) begin
						rx_valid <= 1'b1;
						pwr_up_req <= 1'b1;
					end
				end
				default: phase <= ph_idle;
			endcase
		end
	end

	// message payload
	always_ff @(posedge clk_ext) begin
		if (tx_load)
			tx_shift <= {tx_msg.broadcast ? broadcast_addr : tx_msg.addr, tx_msg.data};
		else if (bit_fall)
			tx_shift <= {tx_shift[msg_bits-2:0], 1'b0};
		if (bit_rise)
			rx_shift <= {rx_shift[msg_bits-2:0], din_s};
		if (rx_store) begin
			rx_msg.addr <= rx_shift[msg_bits-1 -: addr_width];
			rx_msg.data <= rx_shift[data_width-1:0];
			rx_msg.broadcast <= (rx_shift[msg_bits-1 -: addr_width] == broadcast_addr);
		end
	end

	// the layer must be powered before it sees a message
	rx_req_powered: assert property (@(posedge clk_ext) disable iff (!arst_n)
		$rose(rx_req) |-> $past(layer_ready));

endmodule

`default_nettype wire

// File: verilog/mbus_pkg.sv
`default_nettype none

package mbus_pkg;

	// frame field widths
	localparam int addr_width = 8;
	localparam int data_width = 32;

	// address and data travel through one shift register
	localparam int msg_bits = addr_width + data_width;

	// arbitration + address + data + acknowledge
	localparam int frame_bits = 1 + msg_bits + 1;

	// wide enough to count every bit of a frame
	localparam int cnt_width = $clog2(frame_bits);

	// every member node accepts frames to this address
	localparam logic [addr_width-1:0] broadcast_addr = 8'h00;

	// sleep command, consumed by the node and never handed to the layer
	localparam logic [addr_width-1:0] sleep_addr = 8'h01;

	// where the node is inside the current frame
	typedef enum logic [2:0] {
		ph_idle,	// bus idle, waiting for clkin to move
		ph_arb,		// arbitration bit in flight
		ph_addr,	// address bits, msb first
		ph_data,	// data bits, msb first
		ph_ack,		// acknowledge bit
		ph_done		// one cycle of frame wrap-up
	} frame_phase_e;

	// one message on the transmit or receive port
	typedef struct packed {
		logic [addr_width-1:0] addr;
		logic [data_width-1:0] data;
		logic                  broadcast;	// addr is broadcast_addr
	} mbus_msg_t;

endpackage

`default_nettype wire

// File: verilog/mbus_sleep_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module mbus_sleep_ctrl
	import layer_pkg::*;
(
	input  wire  clk_ext,
	input  wire  arst_n,
	input  wire  din,
	input  wire  wakeup_proc,
	input  wire  int_pending,
	input  wire  sleep_req,
	output logic node_en,
	output logic iso,
	output logic rst_release
);

	sleep_state_e state;
	logic [1:0] din_sync;
	logic din_d;
	logic din_fall;
	logic wake;
	logic [wake_cnt_width-1:0] wake_cnt;

	// din is asynchronous to clk_ext
	always_ff @(posedge clk_ext or negedge arst_n) begin
		if (!arst_n) begin
			din_sync <= 2'b11;
			din_d <= 1'b1;
		end else begin
			din_sync <= {din_sync[0], din};
			din_d <= din_sync[1];
		end
	end

	assign din_fall = din_d & ~din_sync[1];	// start of bus activity
	assign wake = din_fall | wakeup_proc | int_pending;

	always_ff @(posedge clk_ext or negedge arst_n) begin
		if (!arst_n) begin
			state <= st_asleep;
			wake_cnt <= '0;
			iso <= 1'b1;
			rst_release <= 1'b0;
		end else begin
			case (state)
				st_asleep: begin
					wake_cnt <= '0;
					if (wake)
						state <= st_waking;
				end
				st_waking: begin
					wake_cnt <= wake_cnt + 1'b1;
					if (wake_cnt == wake_cnt_width'(wake_cycles - 1)) begin
						state <= st_active;
						iso <= 1'b0;		// isolation and reset lift together
						rst_release <= 1'b1;
					end
				end
				st_active: begin
					if (sleep_req) begin
						state <= st_asleep;
						iso <= 1'b1;
						rst_release <= 1'b0;
					end
				end
				default: state <= st_asleep;
			endcase
		end
	end

	assign node_en = (state != st_asleep);	// clock enable for the node

	iso_rst_excl: assert property (@(posedge clk_ext) disable iff (!arst_n)
		!(iso && rst_release));

	// isolation lifts a fixed number of cycles after the node starts running
	wake_delay: assert property (@(posedge clk_ext) disable iff (!arst_n)
		$rose(node_en) |-> ##(wake_cycles) $fell(iso));

endmodule

`default_nettype wire

// File: verilog/mbus_wire_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module mbus_wire_ctrl (
	input  wire  clk_ext,
	input  wire  arst_n,
	input  wire  din,
	input  wire  clkin,
	input  wire  iso,
	input  wire  node_dout,
	input  wire  node_clkout,
	input  wire  req_int,
	input  wire  clr_int,
	output logic dout,
	output logic clkout,
	output logic int_pending
);

	logic req_int_d;
	logic int_drive;

	// interrupt latch set on a rising req_int
	always_ff @(posedge clk_ext or negedge arst_n) begin
		if (!arst_n) begin
			req_int_d <= 1'b0;
			int_pending <= 1'b0;
		end else begin
			req_int_d <= req_int;
			if (req_int && !req_int_d)
				int_pending <= 1'b1;	// a fresh request wins over clear
			else if (clr_int)
				int_pending <= 1'b0;
		end
	end

	// only pull dout low while the bus clock is parked high
	assign int_drive = int_pending & clkin;

	// bypass path while the node is isolated
	assign dout = iso ? (din & ~int_drive) : node_dout;
	assign clkout = iso ? clkin : node_clkout;

endmodule

`default_nettype wire
